// File: flist.f
+incdir+.
id_pkg.sv
id_dec_if.sv
id_decoder.sv
id_exec_ctrl.sv
id_operand_mux.sv
id_result.sv
id_stage.sv
tb_id_stage.sv

// File: id_dec_if.sv
/*
 * Decoded control bundle, driven by the decoder and read by the
 * sequencer, operand mux and result logic through their modports.
 */

interface id_dec_if;

  id_pkg::alu_op_e    alu_operator;
  id_pkg::op_a_sel_e  op_a_sel;
  id_pkg::op_b_sel_e  op_b_sel;
  id_pkg::imm_b_sel_e imm_b_sel;
  // Sign-extended immediates, one per format
  logic [id_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                    rf_we;
  id_pkg::rf_wd_sel_e      rf_wd_sel;
  logic                    lsu_req, lsu_we, lsu_sign_ext;
  id_pkg::lsu_type_e       lsu_type;
  // Class flags for the sequencer
  logic                    branch, jump, illegal;

  modport decoder (
    output alu_operator, op_a_sel, op_b_sel, imm_b_sel, imm_i, imm_s, imm_b, imm_u, imm_j,
           rf_we, rf_wd_sel, lsu_req, lsu_we, lsu_type, lsu_sign_ext, branch, jump, illegal
  );
  modport exec    (input lsu_req, branch, jump, illegal);
  modport operand (input op_a_sel, op_b_sel, imm_b_sel, imm_i, imm_s, imm_b, imm_u, imm_j);
  modport result  (input rf_we, rf_wd_sel, lsu_type, lsu_sign_ext, illegal);

endinterface

// File: id_decoder.sv
/*
 * RV32I instruction decoder. Purely combinational; branch and jump
 * control depends on whether the instruction is in its first cycle.
 */

module id_decoder #(
  parameter bit Rv32e = 1'b0
) (
  input  logic [id_pkg::XLEN-1:0]       instr_rdata_i,
  input  logic                          instr_first_cycle_i,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  id_dec_if.decoder                     dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal_op;
  logic       rs1_used;
  logic       rs2_used;
  logic       illegal_reg;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Register fields sit at fixed positions
  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  //////////////////////////////
  // Immediates
  //////////////////////////////

  assign dec.imm_i = {{(id_pkg::XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign dec.imm_s = {{(id_pkg::XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:25],
                      instr_rdata_i[11:7]};
  assign dec.imm_b = {{(id_pkg::XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[7],
                      instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign dec.imm_u = {instr_rdata_i[31:12], 12'b0};
  assign dec.imm_j = {{(id_pkg::XLEN-20){instr_rdata_i[31]}}, instr_rdata_i[19:12],
                      instr_rdata_i[20], instr_rdata_i[30:21], 1'b0};

  //////////////////////////////
  // Control decode
  //////////////////////////////

  always_comb begin
    dec.alu_operator = id_pkg::ALU_ADD;
    dec.op_a_sel     = id_pkg::OP_A_REG_A;
    dec.op_b_sel     = id_pkg::OP_B_IMM;
    dec.imm_b_sel    = id_pkg::IMM_B_I;
    dec.rf_we        = 1'b0;
    dec.rf_wd_sel    = id_pkg::RF_WD_EX;
    dec.lsu_req      = 1'b0;
    dec.lsu_we       = 1'b0;
    dec.lsu_type     = id_pkg::LSU_WORD;
    dec.lsu_sign_ext = 1'b0;
    dec.branch       = 1'b0;
    dec.jump         = 1'b0;
    illegal_op       = 1'b0;
    rs1_used         = 1'b0;
    rs2_used         = 1'b0;

    unique case (id_pkg::opcode_e'(opcode))
      id_pkg::OPCODE_LUI: begin
        // 0 + U-immediate
        dec.op_a_sel  = id_pkg::OP_A_ZERO;
        dec.imm_b_sel = id_pkg::IMM_B_U;
        dec.rf_we     = 1'b1;
      end
      id_pkg::OPCODE_AUIPC: begin
        dec.op_a_sel  = id_pkg::OP_A_CURRPC;
        dec.imm_b_sel = id_pkg::IMM_B_U;
        dec.rf_we     = 1'b1;
      end
      id_pkg::OPCODE_JAL, id_pkg::OPCODE_JALR: begin
        dec.jump   = 1'b1;
        dec.rf_we  = 1'b1;
        if (opcode == id_pkg::OPCODE_JALR) begin
          illegal_op = (funct3 != 3'b000);
        end
        if (instr_first_cycle_i) begin
          // Target: PC + J-imm, or rs1 + I-imm
          if (opcode == id_pkg::OPCODE_JAL) begin
            dec.op_a_sel  = id_pkg::OP_A_CURRPC;
            dec.imm_b_sel = id_pkg::IMM_B_J;
          end else begin
            rs1_used = 1'b1;
          end
        end else begin
          // Link address
          dec.op_a_sel  = id_pkg::OP_A_CURRPC;
          dec.imm_b_sel = id_pkg::IMM_B_INCR_PC;
        end
      end
      id_pkg::OPCODE_BRANCH: begin
        dec.branch = 1'b1;
        unique case (funct3)
          3'b000:  dec.alu_operator = id_pkg::ALU_EQ;
          3'b001:  dec.alu_operator = id_pkg::ALU_NE;
          3'b100:  dec.alu_operator = id_pkg::ALU_LT;
          3'b101:  dec.alu_operator = id_pkg::ALU_GE;
          3'b110:  dec.alu_operator = id_pkg::ALU_LTU;
          3'b111:  dec.alu_operator = id_pkg::ALU_GEU;
          default: illegal_op = 1'b1;
        endcase
        if (instr_first_cycle_i) begin
          // Compare rs1 against rs2
          dec.op_b_sel = id_pkg::OP_B_REG_B;
          rs1_used     = 1'b1;
          rs2_used     = 1'b1;
        end else begin
          // Taken: target is PC + B-imm
          dec.alu_operator = id_pkg::ALU_ADD;
          dec.op_a_sel     = id_pkg::OP_A_CURRPC;
          dec.imm_b_sel    = id_pkg::IMM_B_B;
        end
      end
      id_pkg::OPCODE_LOAD: begin
        dec.lsu_req      = 1'b1;
        dec.rf_we        = 1'b1;
        dec.rf_wd_sel    = id_pkg::RF_WD_LSU;
        dec.lsu_sign_ext = ~funct3[2];
        rs1_used         = 1'b1;
        unique case (funct3)
          3'b000, 3'b100: dec.lsu_type = id_pkg::LSU_BYTE;
          3'b001, 3'b101: dec.lsu_type = id_pkg::LSU_HALF;
          3'b010:         dec.lsu_type = id_pkg::LSU_WORD;
          default:        illegal_op = 1'b1;
        endcase
      end
      id_pkg::OPCODE_STORE: begin
        dec.lsu_req   = 1'b1;
        dec.lsu_we    = 1'b1;
        dec.imm_b_sel = id_pkg::IMM_B_S;
        rs1_used      = 1'b1;
        rs2_used      = 1'b1;
        unique case (funct3)
          3'b000:  dec.lsu_type = id_pkg::LSU_BYTE;
          3'b001:  dec.lsu_type = id_pkg::LSU_HALF;
          3'b010:  dec.lsu_type = id_pkg::LSU_WORD;
          default: illegal_op = 1'b1;
        endcase
      end
      id_pkg::OPCODE_OP_IMM, id_pkg::OPCODE_OP: begin
        dec.rf_we = 1'b1;
        rs1_used  = 1'b1;
        if (opcode == id_pkg::OPCODE_OP) begin
          dec.op_b_sel = id_pkg::OP_B_REG_B;
          rs2_used     = 1'b1;
        end
        unique case (funct3)
          3'b000: begin
            // SUB only exists in register form
            if (opcode == id_pkg::OPCODE_OP && funct7 == 7'b0100000) begin
              dec.alu_operator = id_pkg::ALU_SUB;
            end else begin
              illegal_op = (opcode == id_pkg::OPCODE_OP) && (funct7 != 7'b0);
            end
          end
          3'b001: begin
            dec.alu_operator = id_pkg::ALU_SLL;
            illegal_op       = (funct7 != 7'b0);
          end
          3'b010: dec.alu_operator = id_pkg::ALU_SLT;
          3'b011: dec.alu_operator = id_pkg::ALU_SLTU;
          3'b100: dec.alu_operator = id_pkg::ALU_XOR;
          3'b101: begin
            dec.alu_operator = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            illegal_op       = ({funct7[6], funct7[4:0]} != 6'b0);
          end
          3'b110: dec.alu_operator = id_pkg::ALU_OR;
          default: dec.alu_operator = id_pkg::ALU_AND;
        endcase
        // Remaining funct7 bits must be clear in register form
        if (opcode == id_pkg::OPCODE_OP && funct3 inside {3'b010, 3'b011, 3'b100,
                                                          3'b110, 3'b111}) begin
          illegal_op = (funct7 != 7'b0);
        end
      end
      default: illegal_op = 1'b1;
    endcase
  end

  // RV32E has x0..x15 only
  assign illegal_reg = Rv32e & ((rs1_used & rf_raddr_a_o[4]) | (rs2_used & rf_raddr_b_o[4]) |
                                (dec.rf_we & rf_waddr_o[4]));
  assign dec.illegal = illegal_op | illegal_reg;

endmodule

// File: id_exec_ctrl.sv
/*
 * Two-state sequencer of the decode stage. Derives stalls, done, the
 * single LSU request and the PC-set pulse for branches and jumps.
 */

module id_exec_ctrl (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   instr_valid_i,
  input  logic   branch_decision_i,
  input  logic   lsu_resp_valid_i,
  id_dec_if.exec dec,
  output logic   instr_first_cycle_o,
  output logic   instr_done_o,
  output logic   id_in_ready_o,
  output logic   lsu_req_o,
  output logic   pc_set_o
);

  id_pkg::id_fsm_e state_q, state_d;

  logic lsu_insn;
  logic branch_insn;
  logic jump_insn;
  logic stall_mem;
  logic stall_branch;
  logic stall_jump;
  logic pc_set;

  // Illegal instructions behave as plain single-cycle ops
  assign lsu_insn    = dec.lsu_req & ~dec.illegal;
  assign branch_insn = dec.branch & ~dec.illegal;
  assign jump_insn   = dec.jump & ~dec.illegal;

  //////////////////////////////
  // Next state and stalls
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    stall_mem    = 1'b0;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    pc_set       = 1'b0;

    if (instr_valid_i) begin
      unique case (state_q)
        id_pkg::FIRST_CYCLE: begin
          if (lsu_insn) begin
            // Response never counts in the request cycle
            state_d   = id_pkg::MULTI_CYCLE;
            stall_mem = 1'b1;
          end else if (branch_insn && branch_decision_i) begin
            state_d      = id_pkg::MULTI_CYCLE;
            stall_branch = 1'b1;
          end else if (jump_insn) begin
            // Target already on the ALU
            state_d    = id_pkg::MULTI_CYCLE;
            stall_jump = 1'b1;
            pc_set     = 1'b1;
          end
        end
        id_pkg::MULTI_CYCLE: begin
          if (lsu_insn && !lsu_resp_valid_i) begin
            stall_mem = 1'b1;
          end else begin
            state_d = id_pkg::FIRST_CYCLE;
            // Taken branch target shows up now
            pc_set  = branch_insn;
          end
        end
        default: state_d = id_pkg::FIRST_CYCLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= id_pkg::FIRST_CYCLE;
    end else if (instr_valid_i) begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign instr_first_cycle_o = instr_valid_i & (state_q == id_pkg::FIRST_CYCLE);
  assign instr_done_o        = instr_valid_i & ~(stall_mem | stall_branch | stall_jump);
  // Ready for the next word once done, or when idle
  assign id_in_ready_o       = instr_done_o | ~instr_valid_i;
  assign lsu_req_o           = instr_first_cycle_o & lsu_insn;
  assign pc_set_o            = pc_set;

endmodule

// File: id_operand_mux.sv
/*
 * ALU operand selection from register data, PC and immediates.
 */

module id_operand_mux (
  input  logic [id_pkg::XLEN-1:0] pc_id_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_b_i,
  id_dec_if.operand               dec,
  output logic [id_pkg::XLEN-1:0] alu_operand_a_o,
  output logic [id_pkg::XLEN-1:0] alu_operand_b_o
);

  logic [id_pkg::XLEN-1:0] imm_b;

  // Operand A
  always_comb begin
    unique case (dec.op_a_sel)
      id_pkg::OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      id_pkg::OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:             alu_operand_a_o = '0;
    endcase
  end

  // Immediate by format, increment is always 4
  always_comb begin
    unique case (dec.imm_b_sel)
      id_pkg::IMM_B_I: imm_b = dec.imm_i;
      id_pkg::IMM_B_S: imm_b = dec.imm_s;
      id_pkg::IMM_B_B: imm_b = dec.imm_b;
      id_pkg::IMM_B_U: imm_b = dec.imm_u;
      id_pkg::IMM_B_J: imm_b = dec.imm_j;
      default:         imm_b = id_pkg::XLEN'(4);
    endcase
  end

  // Operand B
  assign alu_operand_b_o = (dec.op_b_sel == id_pkg::OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

// File: id_pkg.sv
/*
 * Shared widths and encodings for the RV32I decode stage.
 * Every RTL file refers to these by scoped name.
 */

package id_pkg;

  // Data and register address widths
  parameter int unsigned XLEN       = 32;
  parameter int unsigned REG_ADDR_W = 5;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU operator, arithmetic first, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ,  ALU_NE,  ALU_LT,  ALU_GE,
    ALU_LTU, ALU_GEU
  } alu_op_e;

  //////////////////////////////
  // Operand and result selects
  //////////////////////////////

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  // Immediate kind for operand B
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic {RF_WD_EX, RF_WD_LSU} rf_wd_sel_e;

  // Access size, same coding as the LSU data_type
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // Sequencer state
  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

endpackage

// File: id_result.sv
/*
 * Register write enable and write data. Load data arrives
 * right-aligned and is extended here by size and sign.
 */

module id_result (
  input  logic                    instr_done_i,
  input  logic [id_pkg::XLEN-1:0] result_ex_i,
  input  logic [id_pkg::XLEN-1:0] lsu_rdata_i,
  id_dec_if.result                dec,
  output logic                    rf_we_o,
  output logic [id_pkg::XLEN-1:0] rf_wdata_o
);

  logic [id_pkg::XLEN-1:0] load_data;

  // Write only once, in the done cycle
  assign rf_we_o = instr_done_i & dec.rf_we & ~dec.illegal;

  // Byte and half extension
  always_comb begin
    unique case (dec.lsu_type)
      id_pkg::LSU_BYTE: begin
        load_data = {{(id_pkg::XLEN-8){dec.lsu_sign_ext & lsu_rdata_i[7]}}, lsu_rdata_i[7:0]};
      end
      id_pkg::LSU_HALF: begin
        load_data = {{(id_pkg::XLEN-16){dec.lsu_sign_ext & lsu_rdata_i[15]}},
                     lsu_rdata_i[15:0]};
      end
      default: load_data = lsu_rdata_i;
    endcase
  end

  assign rf_wdata_o = (dec.rf_wd_sel == id_pkg::RF_WD_LSU) ? load_data : result_ex_i;

endmodule

// File: id_stage.sv
/*
 * Decode stage top level for an RV32I core without writeback stage.
 * ALU, LSU and register file are external; this block only connects.
 */

module id_stage #(
  parameter bit Rv32e = 1'b0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Fetch side
  input  logic                          instr_valid_i,
  input  logic [id_pkg::XLEN-1:0]       instr_rdata_i,
  input  logic [id_pkg::XLEN-1:0]       pc_id_i,
  output logic                          id_in_ready_o,
  output logic                          instr_done_o,
  output logic                          illegal_insn_o,
  output logic                          pc_set_o,
  // Register file
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_b_i,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic                          rf_we_o,
  output logic [id_pkg::XLEN-1:0]       rf_wdata_o,
  // ALU
  input  logic                          branch_decision_i,
  input  logic [id_pkg::XLEN-1:0]       result_ex_i,
  output id_pkg::alu_op_e               alu_operator_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_a_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_b_o,
  // LSU
  input  logic                          lsu_resp_valid_i,
  input  logic [id_pkg::XLEN-1:0]       lsu_rdata_i,
  output logic                          lsu_req_o,
  output logic                          lsu_we_o,
  output id_pkg::lsu_type_e             lsu_type_o,
  output logic                          lsu_sign_ext_o,
  output logic [id_pkg::XLEN-1:0]       lsu_wdata_o
);

  logic instr_first_cycle;

  id_dec_if dec_if ();

  id_decoder #(
    .Rv32e (Rv32e)
  ) decoder_i (
    .instr_rdata_i       (instr_rdata_i),
    .instr_first_cycle_i (instr_first_cycle),
    .rf_raddr_a_o        (rf_raddr_a_o),
    .rf_raddr_b_o        (rf_raddr_b_o),
    .rf_waddr_o          (rf_waddr_o),
    .dec                 (dec_if)
  );

  id_exec_ctrl exec_ctrl_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .branch_decision_i   (branch_decision_i),
    .lsu_resp_valid_i    (lsu_resp_valid_i),
    .dec                 (dec_if),
    .instr_first_cycle_o (instr_first_cycle),
    .instr_done_o        (instr_done_o),
    .id_in_ready_o       (id_in_ready_o),
    .lsu_req_o           (lsu_req_o),
    .pc_set_o            (pc_set_o)
  );

  id_operand_mux operand_mux_i (
    .pc_id_i         (pc_id_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .dec             (dec_if),
    .alu_operand_a_o (alu_operand_a_o),
    .alu_operand_b_o (alu_operand_b_o)
  );

  id_result result_i (
    .instr_done_i (instr_done_o),
    .result_ex_i  (result_ex_i),
    .lsu_rdata_i  (lsu_rdata_i),
    .dec          (dec_if),
    .rf_we_o      (rf_we_o),
    .rf_wdata_o   (rf_wdata_o)
  );

  // Decoded attributes straight out
  assign illegal_insn_o = instr_valid_i & dec_if.illegal;
  assign alu_operator_o = dec_if.alu_operator;
  assign lsu_we_o       = dec_if.lsu_we;
  assign lsu_type_o     = dec_if.lsu_type;
  assign lsu_sign_ext_o = dec_if.lsu_sign_ext;
  // Store data is rs2
  assign lsu_wdata_o    = rf_rdata_b_i;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it once

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f flist.f --top-module tb_id_stage -Mdir obj_dir -o sim; then
  echo "Verilator build failed"
  exit 1
fi

out="$(./obj_dir/sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  exit 1
fi
if grep -qx "Simulation passed" <<< "$out"; then
  exit 0
fi
exit 1

// File: tb_id_vectors.svh
/*
 * Instruction table for the decode stage testbench, one row per
 * instruction. Included inside the testbench top module.
 */

`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// Register data, execute result and kind of sequence
localparam logic [31:0] RS1 = 32'h8000_0010;
localparam logic [31:0] RS2 = 32'h0000_0230;
localparam logic [31:0] EXR = 32'h5a5a_0001;
localparam logic [1:0]  ONE = 2'd0;   // done in cycle 1
localparam logic [1:0]  TWO = 2'd1;   // done in cycle 2
localparam logic [1:0]  MEM = 2'd2;   // done on LSU response

typedef struct packed {
  logic [31:0]       instr;
  logic [31:0]       pc;
  logic              taken;
  logic [31:0]       ldata;
  logic [1:0]        kind;
  logic [1:0]        pcset;   // cycle of pc_set_o, 0 for none
  logic              we;
  logic [31:0]       wdata;
  id_pkg::lsu_type_e ltype;
  logic              lsign;
  logic              lwe;
  logic              illegal;
  id_pkg::alu_op_e   op1;
  logic [31:0]       a1;
  logic [31:0]       b1;
  id_pkg::alu_op_e   op2;
  logic [31:0]       a2;
  logic [31:0]       b2;
  // Expected rs1, rs2 and rd addresses
  logic [4:0]        ra;
  logic [4:0]        rb;
  logic [4:0]        rd;
} vec_t;

localparam int NUM_VEC = 17;

string vec_names [NUM_VEC] = '{
  "add", "sub", "addi", "srai", "lui", "auipc", "beq_not_taken", "bne_taken", "jal",
  "jalr", "lb", "lhu", "lw", "sw", "sb", "illegal_opcode", "illegal_funct7"
};

localparam vec_t VECS [NUM_VEC] = '{
  '{32'h002081b3, 32'h100, 1'b0, 32'h0, ONE, 2'd0,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_ADD, RS1, RS2, id_pkg::ALU_ADD, RS1, RS2, 5'd1, 5'd2, 5'd3},
  '{32'h407302b3, 32'h104, 1'b0, 32'h0, ONE, 2'd0,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_SUB, RS1, RS2, id_pkg::ALU_SUB, RS1, RS2, 5'd6, 5'd7, 5'd5},
  '{32'hffd10093, 32'h108, 1'b0, 32'h0, ONE, 2'd0,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_ADD, RS1, 32'hfffffffd, id_pkg::ALU_ADD, RS1, 32'hfffffffd, 5'd2, 5'd29, 5'd1},
  '{32'h40325213, 32'h10c, 1'b0, 32'h0, ONE, 2'd0,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_SRA, RS1, 32'h00000403, id_pkg::ALU_SRA, RS1, 32'h00000403, 5'd4, 5'd3, 5'd4},
  '{32'h123453b7, 32'h110, 1'b0, 32'h0, ONE, 2'd0,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_ADD, 32'h0, 32'h12345000, id_pkg::ALU_ADD, 32'h0, 32'h12345000, 5'd8, 5'd3, 5'd7},
  '{32'h00001497, 32'h114, 1'b0, 32'h0, ONE, 2'd0,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_ADD, 32'h114, 32'h1000, id_pkg::ALU_ADD, 32'h114, 32'h1000, 5'd0, 5'd0, 5'd9},
  '{32'h00208463, 32'h118, 1'b0, 32'h0, ONE, 2'd0,
    1'b0, 32'h0, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_EQ, RS1, RS2, id_pkg::ALU_EQ, RS1, RS2, 5'd1, 5'd2, 5'd8},
  '{32'hfe419ee3, 32'h11c, 1'b1, 32'h0, TWO, 2'd2,
    1'b0, 32'h0, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_NE, RS1, RS2, id_pkg::ALU_ADD, 32'h11c, 32'hfffffffc, 5'd3, 5'd4, 5'd29},
  '{32'h010000ef, 32'h120, 1'b0, 32'h0, TWO, 2'd1,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_ADD, 32'h120, 32'h10, id_pkg::ALU_ADD, 32'h120, 32'h4, 5'd0, 5'd16, 5'd1},
  '{32'h008302e7, 32'h124, 1'b0, 32'h0, TWO, 2'd1,
    1'b1, EXR, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_ADD, RS1, 32'h8, id_pkg::ALU_ADD, 32'h124, 32'h4, 5'd6, 5'd8, 5'd5},
  '{32'h00410403, 32'h128, 1'b0, 32'h12345680, MEM, 2'd0,
    1'b1, 32'hffffff80, id_pkg::LSU_BYTE, 1'b1, 1'b0, 1'b0,
    id_pkg::ALU_ADD, RS1, 32'h4, id_pkg::ALU_ADD, RS1, 32'h4, 5'd2, 5'd4, 5'd8},
  '{32'h0021d483, 32'h12c, 1'b0, 32'habcd8001, MEM, 2'd0,
    1'b1, 32'h00008001, id_pkg::LSU_HALF, 1'b0, 1'b0, 1'b0,
    id_pkg::ALU_ADD, RS1, 32'h2, id_pkg::ALU_ADD, RS1, 32'h2, 5'd3, 5'd2, 5'd9},
  '{32'h0000a503, 32'h130, 1'b0, 32'hdeadbeef, MEM, 2'd0,
    1'b1, 32'hdeadbeef, id_pkg::LSU_WORD, 1'b1, 1'b0, 1'b0,
    id_pkg::ALU_ADD, RS1, 32'h0, id_pkg::ALU_ADD, RS1, 32'h0, 5'd1, 5'd0, 5'd10},
  '{32'h0020a623, 32'h134, 1'b0, 32'h0, MEM, 2'd0,
    1'b0, 32'h0, id_pkg::LSU_WORD, 1'b0, 1'b1, 1'b0,
    id_pkg::ALU_ADD, RS1, 32'hc, id_pkg::ALU_ADD, RS1, 32'hc, 5'd1, 5'd2, 5'd12},
  '{32'hfe530fa3, 32'h138, 1'b0, 32'h0, MEM, 2'd0,
    1'b0, 32'h0, id_pkg::LSU_BYTE, 1'b0, 1'b1, 1'b0,
    id_pkg::ALU_ADD, RS1, 32'hffffffff, id_pkg::ALU_ADD, RS1, 32'hffffffff, 5'd6, 5'd5, 5'd31},
  '{32'h0000007f, 32'h13c, 1'b0, 32'h0, ONE, 2'd0,
    1'b0, 32'h0, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b1,
    id_pkg::ALU_ADD, RS1, 32'h0, id_pkg::ALU_ADD, RS1, 32'h0, 5'd0, 5'd0, 5'd0},
  '{32'h022081b3, 32'h140, 1'b0, 32'h0, ONE, 2'd0,
    1'b0, 32'h0, id_pkg::LSU_WORD, 1'b0, 1'b0, 1'b1,
    id_pkg::ALU_ADD, RS1, RS2, id_pkg::ALU_ADD, RS1, RS2, 5'd1, 5'd2, 5'd3}
};

`endif

// File: tb_id_stage.sv
/*
 * Testbench for the decode stage. Applies the instruction table row
 * by row, checks every cycle until done and the idle cycle after it.
 */

module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_id_vectors.svh"

  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES   = NUM_VEC * 8 + RESET_CYCLES;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic                          instr_valid_i, branch_decision_i, lsu_resp_valid_i;
  logic [id_pkg::XLEN-1:0]       instr_rdata_i, pc_id_i, rf_rdata_a_i, rf_rdata_b_i;
  logic [id_pkg::XLEN-1:0]       result_ex_i, lsu_rdata_i;
  logic                          id_in_ready_o, instr_done_o, illegal_insn_o, pc_set_o;
  logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
  logic                          rf_we_o, lsu_req_o, lsu_we_o, lsu_sign_ext_o;
  logic [id_pkg::XLEN-1:0]       rf_wdata_o, alu_operand_a_o, alu_operand_b_o, lsu_wdata_o;
  id_pkg::alu_op_e               alu_operator_o;
  id_pkg::lsu_type_e             lsu_type_o;
  string                         tname = "reset";
  int unsigned                   cycle_cnt = 0;

  id_stage dut_i (.*);

  always #5 clk_i = ~clk_i;

  // Run limit from the table length
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Simulation failed");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  ////////////////////////////////
  // Compare tasks
  ////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopped at test %s", tname);
  endtask

  task automatic word_check(string what, logic [id_pkg::XLEN-1:0] exp,
                            logic [id_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s %s expected %h actual %h", tname, what, exp, act);
      abort_run();
    end
  endtask

  task automatic addr_check(string what, logic [id_pkg::REG_ADDR_W-1:0] exp,
                            logic [id_pkg::REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s %s expected %0d actual %0d", tname, what, exp, act);
      abort_run();
    end
  endtask

  task automatic op_check(id_pkg::alu_op_e exp, id_pkg::alu_op_e act);
    if (act !== exp) begin
      $display("** Error: %s alu_operator expected %s actual %s", tname, exp.name(),
               act.name());
      abort_run();
    end
  endtask

  task automatic type_check(id_pkg::lsu_type_e exp, id_pkg::lsu_type_e act);
    if (act !== exp) begin
      $display("** Error: %s lsu_type expected %s actual %s", tname, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic flag_check(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error: %s %s expected %b actual %b", tname, what, exp, act);
      abort_run();
    end
  endtask

  // Nothing pending, stage ready
  task automatic verify_idle();
    flag_check("instr_done_o", 1'b0, instr_done_o);
    flag_check("rf_we_o", 1'b0, rf_we_o);
    flag_check("lsu_req_o", 1'b0, lsu_req_o);
    flag_check("pc_set_o", 1'b0, pc_set_o);
    flag_check("id_in_ready_o", 1'b1, id_in_ready_o);
  endtask

  // One cycle of an instruction; phase 2 only for taken branches and jumps
  task automatic observe_cycle(vec_t v, int unsigned cyc, int unsigned delay,
                               output logic done);
    logic phase2;
    logic exp_done;
    phase2 = (v.kind == TWO) && (cyc == 2);
    if (v.kind == ONE) exp_done = (cyc == 1);
    else if (v.kind == TWO) exp_done = (cyc == 2);
    else exp_done = (cyc == delay + 1);
    op_check(phase2 ? v.op2 : v.op1, alu_operator_o);
    word_check("alu_operand_a_o", phase2 ? v.a2 : v.a1, alu_operand_a_o);
    word_check("alu_operand_b_o", phase2 ? v.b2 : v.b1, alu_operand_b_o);
    addr_check("rf_raddr_a_o", v.ra, rf_raddr_a_o);
    addr_check("rf_raddr_b_o", v.rb, rf_raddr_b_o);
    addr_check("rf_waddr_o", v.rd, rf_waddr_o);
    flag_check("illegal_insn_o", v.illegal, illegal_insn_o);
    flag_check("pc_set_o", cyc == int'(v.pcset), pc_set_o);
    flag_check("lsu_req_o", (v.kind == MEM) && (cyc == 1), lsu_req_o);
    flag_check("instr_done_o", exp_done, instr_done_o);
    flag_check("id_in_ready_o", exp_done, id_in_ready_o);
    flag_check("rf_we_o", exp_done & v.we, rf_we_o);
    if (exp_done && v.we) word_check("rf_wdata_o", v.wdata, rf_wdata_o);
    if (v.kind == MEM && cyc == 1) begin
      type_check(v.ltype, lsu_type_o);
      flag_check("lsu_sign_ext_o", v.lsign, lsu_sign_ext_o);
      flag_check("lsu_we_o", v.lwe, lsu_we_o);
      word_check("lsu_wdata_o", RS2, lsu_wdata_o);
    end
    done = exp_done;
  endtask

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////

  initial begin
    vec_t        v;
    int unsigned cyc;
    int unsigned delay;
    logic        done;
    void'($urandom(32'h4449_894c));
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    branch_decision_i = 1'b0;
    result_ex_i       = '0;
    lsu_resp_valid_i  = 1'b0;
    lsu_rdata_i       = '0;
    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      verify_idle();
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    tname = "after_reset";
    @(negedge clk_i);
    verify_idle();

    for (int i = 0; i < NUM_VEC; i++) begin
      v     = VECS[i];
      tname = vec_names[i];
      delay = 1 + ($urandom % 4);
      @(posedge clk_i);
      instr_valid_i     <= 1'b1;
      instr_rdata_i     <= v.instr;
      pc_id_i           <= v.pc;
      rf_rdata_a_i      <= RS1;
      rf_rdata_b_i      <= RS2;
      branch_decision_i <= v.taken;
      result_ex_i       <= EXR;
      lsu_rdata_i       <= v.ldata;
      // A response in the request cycle must be ignored
      lsu_resp_valid_i  <= (v.kind == MEM);
      cyc  = 1;
      done = 1'b0;
      while (!done) begin
        @(negedge clk_i);
        observe_cycle(v, cyc, delay, done);
        if (!done) begin
          if (cyc >= 8) begin
            $display("Test %s: the instruction never signalled done", tname);
            abort_run();
          end
          @(posedge clk_i);
          cyc = cyc + 1;
          lsu_resp_valid_i <= (v.kind == MEM) && (cyc == delay + 1);
        end
      end
      @(posedge clk_i);
      instr_valid_i     <= 1'b0;
      lsu_resp_valid_i  <= 1'b0;
      branch_decision_i <= 1'b0;
      @(negedge clk_i);
      verify_idle();
    end

    $display("Simulation passed");
    $finish;
  end

endmodule
